// File: hdl/memctl_pkg.sv
// ======================================================================
// Memory controller shared types
// ======================================================================
`default_nettype none

package memctl_pkg;

	// APB address width
	localparam int ADDR_W = 24;
	// Byte lanes on the widest memory bus
	localparam int LANES = 8;

	// Region select sits in the top two address bits
	localparam int REGION_HI = ADDR_W - 1;
	localparam int REGION_LO = ADDR_W - 2;
	// DRAM row runs from here down to ROW_LSB
	localparam int ROW_MSB = REGION_LO - 1;

	// Address space, in the order of paddr[23:22]
	typedef enum logic [1:0] {
		REG_DRAM,
		REG_ROM,
		REG_IO,
		REG_NONE
	} region_t;

	// Physical data width of a region
	typedef enum logic [1:0] {
		MW_8,
		MW_16,
		MW_32,
		MW_64
	} mem_width_t;

	// APB transfer size
	typedef enum logic [1:0] {
		SZ_BYTE,
		SZ_HALF,
		SZ_WORD,
		SZ_DWORD
	} xfer_size_t;

	// Cycle sequencer FSM
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_PRECHARGE,
		ST_RAS,
		ST_CAS,
		ST_ROM,
		ST_IO,
		ST_DONE
	} seq_state_t;

	// One bit per byte lane
	typedef logic [LANES-1:0] lane_mask_t;

	// Strobe requests, issued one clock ahead of the pins
	typedef struct packed {
		region_t region;
		logic ras;
		logic cas;
		logic rom_sel;
		logic io_sel;
		logic wr;
		logic rd;
		logic mux;
	} cycle_phase_t;

	// Memory control pins, all strobes active low
	typedef struct packed {
		logic ras_l;
		logic cas_l;
		logic rom_cs_l;
		logic io_cs_l;
		logic addr_mux;
		lane_mask_t we_l;
		lane_mask_t oe_l;
	} mem_pins_t;

endpackage

`default_nettype wire

// File: hdl/wait_counter.sv
// ======================================================================
// Wait state counter
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

module wait_counter (
	input wire sys_clk,
	input wire resetl,
	input wire load,
	input wire [3:0] count,
	input wire hold_l,
	output wire done
);

	logic [3:0] cnt;

	// Load wins over counting
	// Counter parks at zero until the next load
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			cnt <= 4'd0;
		end else if (load) begin
			cnt <= count;
		end else if (cnt != 4'd0) begin
			cnt <= cnt - 4'd1;
		end
	end

	// Expired count only finishes the phase once the hold is released
	assign done = (cnt == 4'd0) && hold_l;

endmodule

`default_nettype wire

// File: hdl/lane_decoder.sv
// ======================================================================
// Byte lane decoder
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

module lane_decoder import memctl_pkg::*; (
	input wire [ADDR_W-1:0] paddr,
	input xfer_size_t psize,
	output lane_mask_t lanes
);

	lane_mask_t size_mask;
	logic [2:0] base;

	// Lane count and start lane per size
	// Start lane is the byte address aligned down to the size
	always_comb begin
		case (psize)
			SZ_BYTE: begin
				size_mask = 8'h01;
				base = paddr[2:0];
			end
			SZ_HALF: begin
				size_mask = 8'h03;
				base = {paddr[2:1], 1'b0};
			end
			SZ_WORD: begin
				size_mask = 8'h0f;
				base = {paddr[2], 2'b00};
			end
			default: begin
				// Dword covers the whole bus
				size_mask = 8'hff;
				base = 3'd0;
			end
		endcase
	end

	// Aligned start keeps the run inside the eight lanes
	assign lanes = size_mask << base;

endmodule

`default_nettype wire

// File: hdl/strobe_gen.sv
// ======================================================================
// Memory strobe generator
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

module strobe_gen import memctl_pkg::*; #(
	parameter mem_width_t DRAM_WIDTH = MW_64,
	parameter mem_width_t ROM_WIDTH = MW_16,
	parameter mem_width_t IO_WIDTH = MW_8
) (
	input wire sys_clk,
	input wire resetl,
	input cycle_phase_t phase,
	input lane_mask_t lanes,
	output mem_pins_t mem_pins
);

	// Lane j lands on physical lane j modulo the bus width in bytes
	function automatic lane_mask_t fold_lanes(input lane_mask_t in_lanes, input mem_width_t w);
		lane_mask_t folded;
		int w_bytes;
		folded = '0;
		w_bytes = 1 << w;
		for (int j = 0; j < LANES; j++) begin
			if (in_lanes[j]) begin
				folded[j % w_bytes] = 1'b1;
			end
		end
		return folded;
	endfunction

	mem_width_t region_width;
	lane_mask_t bus_lanes;

	always_comb begin
		case (phase.region)
			REG_DRAM: region_width = DRAM_WIDTH;
			REG_ROM: region_width = ROM_WIDTH;
			REG_IO: region_width = IO_WIDTH;
			default: region_width = MW_8;
		endcase
	end

	// Lanes above the width never get set
	assign bus_lanes = fold_lanes(lanes, region_width);

	// Pins lag phase by one clock
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			mem_pins <= '{ras_l: 1'b1, cas_l: 1'b1, rom_cs_l: 1'b1, io_cs_l: 1'b1,
				addr_mux: 1'b0, we_l: '1, oe_l: '1};
		end else begin
			mem_pins.ras_l <= !phase.ras;
			mem_pins.cas_l <= !phase.cas;
			mem_pins.rom_cs_l <= !phase.rom_sel;
			mem_pins.io_cs_l <= !phase.io_sel;
			mem_pins.addr_mux <= phase.mux;
			mem_pins.we_l <= phase.wr ? ~bus_lanes : '1;
			mem_pins.oe_l <= phase.rd ? ~bus_lanes : '1;
		end
	end

endmodule

`default_nettype wire

// File: hdl/mem_sequencer.sv
// ======================================================================
// Memory cycle sequencer
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

module mem_sequencer import memctl_pkg::*; #(
	parameter int T_RP = 2,
	parameter int T_RCD = 2,
	parameter int T_CAS = 2,
	parameter int ROM_WAIT = 3,
	parameter int IO_WAIT = 1,
	parameter int ROW_LSB = 11
) (
	input wire sys_clk,
	input wire resetl,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [ADDR_W-1:0] paddr,
	input wire wait_l,
	output logic pready,
	output logic pslverr,
	output cycle_phase_t phase
);

	// Counter loads are phase length minus one
	localparam logic [3:0] RP_CNT = 4'(T_RP - 1);
	localparam logic [3:0] RCD_CNT = 4'(T_RCD - 1);
	localparam logic [3:0] CAS_CNT = 4'(T_CAS - 1);
	localparam logic [3:0] ROM_CNT = 4'(ROM_WAIT);
	localparam logic [3:0] IO_CNT = 4'(IO_WAIT);

	seq_state_t state;
	seq_state_t state_nxt;
	region_t addr_region;
	region_t cur_region;
	region_t region_nxt;
	logic [ROW_MSB:ROW_LSB] open_row;
	logic row_valid;
	logic page_hit;
	logic row_update;
	logic cnt_load;
	logic [3:0] cnt_value;
	logic cnt_done;
	logic hold_l;
	logic dram_nxt;
	logic data_on;

	assign addr_region = region_t'(paddr[REGION_HI:REGION_LO]);
	assign page_hit = row_valid && (paddr[ROW_MSB:ROW_LSB] == open_row);

	// Region is taken from the address only when a cycle starts
	assign region_nxt = (state == ST_IDLE) ? addr_region : cur_region;

	// External wait only stretches I/O cycles
	assign hold_l = (state == ST_IO) ? wait_l : 1'b1;

	wait_counter u_wait (
		.sys_clk(sys_clk),
		.resetl(resetl),
		.load(cnt_load),
		.count(cnt_value),
		.hold_l(hold_l),
		.done(cnt_done)
	);

	// Next state and phase length
	always_comb begin
		state_nxt = state;
		cnt_load = 1'b0;
		cnt_value = 4'd0;
		row_update = 1'b0;
		case (state)
			ST_IDLE: begin
				// Cycle starts in the APB setup cycle
				if (psel && !penable) begin
					cnt_load = 1'b1;
					case (addr_region)
						REG_DRAM: begin
							if (page_hit) begin
								state_nxt = ST_CAS;
								cnt_value = CAS_CNT;
							end else if (row_valid) begin
								state_nxt = ST_PRECHARGE;
								cnt_value = RP_CNT;
								row_update = 1'b1;
							end else begin
								// No page open yet, so no precharge
								state_nxt = ST_RAS;
								cnt_value = RCD_CNT;
								row_update = 1'b1;
							end
						end
						REG_ROM: begin
							state_nxt = ST_ROM;
							cnt_value = ROM_CNT;
						end
						REG_IO: begin
							state_nxt = ST_IO;
							cnt_value = IO_CNT;
						end
						default: state_nxt = ST_DONE;
					endcase
				end
			end
			ST_PRECHARGE: begin
				if (cnt_done) begin
					state_nxt = ST_RAS;
					cnt_load = 1'b1;
					cnt_value = RCD_CNT;
				end
			end
			ST_RAS: begin
				if (cnt_done) begin
					state_nxt = ST_CAS;
					cnt_load = 1'b1;
					cnt_value = CAS_CNT;
				end
			end
			ST_CAS, ST_ROM, ST_IO: begin
				if (cnt_done) begin
					state_nxt = ST_DONE;
				end
			end
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			state <= ST_IDLE;
			row_valid <= 1'b0;
		end else begin
			state <= state_nxt;
			if (row_update) begin
				row_valid <= 1'b1;
			end
		end
	end

	// Open row and cycle region
	always_ff @(posedge sys_clk) begin
		if (row_update) begin
			open_row <= paddr[ROW_MSB:ROW_LSB];
		end
		cur_region <= region_nxt;
	end

	// Phase follows next state, strobe_gen registers it
	always_comb begin
		dram_nxt = (region_nxt == REG_DRAM);
		phase.region = region_nxt;
		phase.ras = (state_nxt == ST_RAS) || (state_nxt == ST_CAS) ||
			(state_nxt == ST_DONE && dram_nxt);
		phase.cas = (state_nxt == ST_CAS) || (state_nxt == ST_DONE && dram_nxt);
		phase.mux = phase.cas;
		phase.rom_sel = (region_nxt == REG_ROM) &&
			(state_nxt == ST_ROM || state_nxt == ST_DONE);
		phase.io_sel = (region_nxt == REG_IO) &&
			(state_nxt == ST_IO || state_nxt == ST_DONE);
		// DRAM data only in the done cycle, ROM and I/O throughout
		data_on = phase.rom_sel || phase.io_sel ||
			(dram_nxt && state_nxt == ST_DONE);
		phase.wr = data_on && pwrite;
		phase.rd = data_on && !pwrite;
	end

	assign pready = (state == ST_DONE);
	assign pslverr = (state == ST_DONE) && (cur_region == REG_NONE);

endmodule

`default_nettype wire

// File: hdl/memctl_top.sv
// ======================================================================
// Memory controller top level
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

module memctl_top import memctl_pkg::*; #(
	// DRAM phase lengths in clocks
	parameter int T_RP = 2,
	parameter int T_RCD = 2,
	parameter int T_CAS = 2,
	// Fixed wait states
	parameter int ROM_WAIT = 3,
	parameter int IO_WAIT = 1,
	// Bus width per region
	parameter mem_width_t DRAM_WIDTH = MW_64,
	parameter mem_width_t ROM_WIDTH = MW_16,
	parameter mem_width_t IO_WIDTH = MW_8,
	parameter int ROW_LSB = 11
) (
	input wire sys_clk,
	input wire resetl,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [ADDR_W-1:0] paddr,
	input xfer_size_t psize,
	output logic pready,
	output logic pslverr,
	input wire wait_l,
	output mem_pins_t mem_pins
);

	cycle_phase_t phase;
	lane_mask_t lanes;

	// Cycle timing and APB completion
	mem_sequencer #(
		.T_RP(T_RP),
		.T_RCD(T_RCD),
		.T_CAS(T_CAS),
		.ROM_WAIT(ROM_WAIT),
		.IO_WAIT(IO_WAIT),
		.ROW_LSB(ROW_LSB)
	) u_seq (
		.sys_clk(sys_clk),
		.resetl(resetl),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.wait_l(wait_l),
		.pready(pready),
		.pslverr(pslverr),
		.phase(phase)
	);

	// Byte lanes straight from the request
	lane_decoder u_lanes (
		.paddr(paddr),
		.psize(psize),
		.lanes(lanes)
	);

	strobe_gen #(
		.DRAM_WIDTH(DRAM_WIDTH),
		.ROM_WIDTH(ROM_WIDTH),
		.IO_WIDTH(IO_WIDTH)
	) u_strobe (
		.sys_clk(sys_clk),
		.resetl(resetl),
		.phase(phase),
		.lanes(lanes),
		.mem_pins(mem_pins)
	);

endmodule

`default_nettype wire

// File: bench/clk_gen.sv
// ======================================================================
// Testbench clock and reset
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

module clk_gen (
	output logic sys_clk,
	output logic resetl
);

	// 20 ns period
	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	// Reset held low for four rising edges
	initial begin
		resetl = 1'b0;
		repeat (4) @(posedge sys_clk);
		#2;
		resetl = 1'b1;
	end

endmodule

`default_nettype wire

// File: bench/memctl_properties.sv
// ======================================================================
// Memory controller assertions
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

module memctl_properties import memctl_pkg::*; (
	input wire sys_clk,
	input wire resetl,
	input wire pready,
	input cycle_phase_t phase,
	input mem_pins_t mem_pins
);

	// Completion is a one-cycle pulse
	pready_single: assert property (@(posedge sys_clk) disable iff (!resetl)
		pready |=> !pready)
		else $error("pready stayed high for more than one cycle");

	// Pins lag the phase by one clock, so the region comes from the cycle before
	ras_cas_dram_only: assert property (@(posedge sys_clk) disable iff (!resetl)
		(!mem_pins.ras_l && !mem_pins.cas_l) |-> ($past(phase.region) == REG_DRAM))
		else $error("ras_l and cas_l both low outside a DRAM cycle");

	// ROM and I/O selects exclusive
	cs_exclusive: assert property (@(posedge sys_clk) disable iff (!resetl)
		!(!mem_pins.rom_cs_l && !mem_pins.io_cs_l))
		else $error("rom_cs_l and io_cs_l low at the same time");

endmodule

bind memctl_top memctl_properties u_props (
	.sys_clk(sys_clk),
	.resetl(resetl),
	.pready(pready),
	.phase(phase),
	.mem_pins(mem_pins)
);

`default_nettype wire

// File: bench/memctl_tb.sv
// ======================================================================
// Memory controller testbench
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

module memctl_tb import memctl_pkg::*; ();

	// DUT defaults
	localparam int T_RP = 2;
	localparam int T_RCD = 2;
	localparam int T_CAS = 2;
	localparam int ROM_WAIT = 3;
	localparam int IO_WAIT = 1;
	// Bus widths in bytes per region
	localparam int DRAM_BYTES = 8;
	localparam int ROM_BYTES = 2;
	localparam int IO_BYTES = 1;
	localparam int NUM_TESTS = 6;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * 40 + 4;
	localparam int MAX_ACCESS = 40;
	localparam mem_pins_t IDLE_PINS = mem_pins_t'({4'b1111, 1'b0, 16'hffff});

	logic sys_clk;
	logic resetl;
	logic psel;
	logic penable;
	logic pwrite;
	logic [ADDR_W-1:0] paddr;
	xfer_size_t psize;
	logic wait_l;
	logic pready;
	logic pslverr;
	mem_pins_t mem_pins;

	int pin_errors;
	int latency_errors;
	int flag_errors;
	int timeouts;
	logic [31:0] rng;
	// Open page as the test sees it
	logic row_open;
	logic [10:0] open_row_model;

	clk_gen u_clk (
		.sys_clk(sys_clk),
		.resetl(resetl)
	);

	memctl_top uut (
		.sys_clk(sys_clk),
		.resetl(resetl),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.psize(psize),
		.pready(pready),
		.pslverr(pslverr),
		.wait_l(wait_l),
		.mem_pins(mem_pins)
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Region in the top bits, then row, then column
	function automatic logic [ADDR_W-1:0] make_addr(input region_t region,
			input logic [10:0] row, input logic [10:0] col);
		return {region, row, col};
	endfunction

	// Run of 1, 2, 4 or 8 lanes from the size-aligned byte offset
	function automatic lane_mask_t expected_lanes(input logic [ADDR_W-1:0] addr,
			input xfer_size_t size);
		lane_mask_t m;
		int bytes;
		int start;
		m = '0;
		bytes = 1 << int'(size);
		start = (int'(addr[2:0]) / bytes) * bytes;
		for (int k = 0; k < bytes; k++) begin
			m[start + k] = 1'b1;
		end
		return m;
	endfunction

	// Physical lane k collects every lane j that lands on it
	function automatic lane_mask_t fold_to_width(input lane_mask_t m, input int width_bytes);
		lane_mask_t f;
		f = '0;
		for (int k = 0; k < width_bytes; k++) begin
			for (int j = k; j < LANES; j += width_bytes) begin
				f[k] = f[k] | m[j];
			end
		end
		return f;
	endfunction

	// Pins seen in the completion cycle
	function automatic mem_pins_t done_pins(input region_t region, input logic write,
			input lane_mask_t bus);
		mem_pins_t p;
		p = IDLE_PINS;
		if (region == REG_DRAM) begin
			p.ras_l = 1'b0;
			p.cas_l = 1'b0;
			p.addr_mux = 1'b1;
		end
		if (region == REG_ROM) p.rom_cs_l = 1'b0;
		if (region == REG_IO) p.io_cs_l = 1'b0;
		if (region != REG_NONE) begin
			if (write) p.we_l = ~bus;
			else p.oe_l = ~bus;
		end
		return p;
	endfunction

	task automatic compare_pins(input mem_pins_t expected, input mem_pins_t actual,
			input string what);
		if (actual !== expected) begin
			$display("FAILED at time %0t: %s pins expected %h got %h", $time, what,
				expected, actual);
			pin_errors++;
		end
	endtask

	task automatic compare_latency(input int expected, input int actual, input string what);
		if (actual != expected) begin
			$display("FAILED at time %0t: %s took %0d cycles, expected %0d", $time, what,
				actual, expected);
			latency_errors++;
		end
	endtask

	task automatic compare_err(input logic expected, input logic actual, input string what);
		if (actual !== expected) begin
			$display("FAILED at time %0t: %s flag expected %b got %b", $time, what,
				expected, actual);
			flag_errors++;
		end
	endtask

	// One APB transfer, counting access cycles up to pready
	task automatic run_transfer(input logic [ADDR_W-1:0] addr, input xfer_size_t size,
			input logic write, input int wait_cycles, output int cycles,
			output mem_pins_t pins, output logic err);
		logic done;
		done = 1'b0;
		cycles = 0;
		pins = IDLE_PINS;
		err = 1'b0;
		// Setup cycle
		@(posedge sys_clk);
		#2;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		psize = size;
		while (!done && cycles < MAX_ACCESS) begin
			@(posedge sys_clk);
			#2;
			penable = 1'b1;
			cycles++;
			// Wait only counts once the fixed wait states are used up
			wait_l = !(cycles > IO_WAIT && cycles <= IO_WAIT + wait_cycles);
			@(negedge sys_clk);
			if (pready) begin
				done = 1'b1;
				pins = mem_pins;
				err = pslverr;
			end
		end
		if (!done) begin
			$display("No pready after %0d access cycles for address %h at time %0t",
				MAX_ACCESS, addr, $time);
			timeouts++;
		end
		@(posedge sys_clk);
		#2;
		psel = 1'b0;
		penable = 1'b0;
		wait_l = 1'b1;
		// Bus back to idle
		@(negedge sys_clk);
		compare_pins(IDLE_PINS, mem_pins, "idle after transfer");
		compare_err(1'b0, pready, "pready after transfer");
	endtask

	task automatic check_transfer(input region_t region, input logic [10:0] row,
			input logic [10:0] col, input xfer_size_t size, input logic write,
			input int wait_cycles, input int exp_cycles, input logic exp_err,
			input string what);
		logic [ADDR_W-1:0] addr;
		int width_bytes;
		int cycles;
		mem_pins_t pins;
		logic err;
		addr = make_addr(region, row, col);
		width_bytes = (region == REG_DRAM) ? DRAM_BYTES :
			(region == REG_ROM) ? ROM_BYTES : IO_BYTES;
		run_transfer(addr, size, write, wait_cycles, cycles, pins, err);
		compare_latency(exp_cycles, cycles, what);
		compare_pins(done_pins(region, write,
			fold_to_width(expected_lanes(addr, size), width_bytes)), pins, what);
		compare_err(exp_err, err, what);
	endtask

	// DRAM access with hit or miss timing from the page model
	task automatic dram_access(input logic [10:0] row, input logic [10:0] col,
			input xfer_size_t size, input logic write, input string what);
		int exp_cycles;
		if (row_open && row == open_row_model) exp_cycles = T_CAS + 1;
		else if (row_open) exp_cycles = T_RP + T_RCD + T_CAS + 1;
		else exp_cycles = T_RCD + T_CAS + 1;
		row_open = 1'b1;
		open_row_model = row;
		check_transfer(REG_DRAM, row, col, size, write, 0, exp_cycles, 1'b0, what);
	endtask

	task automatic test_reset_and_page_open();
		compare_pins(IDLE_PINS, mem_pins, "after reset");
		compare_err(1'b0, pready, "pready after reset");
		dram_access(11'h005, 11'h010, SZ_DWORD, 1'b0, "DRAM read to first row");
		dram_access(11'h005, 11'h3a8, SZ_WORD, 1'b0, "DRAM read in open row");
	endtask

	task automatic test_page_miss();
		dram_access(11'h009, 11'h020, SZ_DWORD, 1'b0, "DRAM read to other row");
	endtask

	task automatic test_dram_random();
		for (int i = 0; i < 12; i++) begin
			rng = lcg_step(rng);
			// Two row bits give a fair share of hits
			dram_access({9'd0, rng[25:24]}, rng[18:8], xfer_size_t'(rng[29:28]),
				(i % 2) == 0, "DRAM random access");
		end
	endtask

	task automatic test_rom();
		check_transfer(REG_ROM, 11'h001, 11'h040, SZ_DWORD, 1'b0, 0, ROM_WAIT + 2, 1'b0,
			"ROM dword read");
		check_transfer(REG_ROM, 11'h001, 11'h005, SZ_BYTE, 1'b1, 0, ROM_WAIT + 2, 1'b0,
			"ROM byte write");
	endtask

	task automatic test_io_wait();
		check_transfer(REG_IO, 11'h000, 11'h004, SZ_WORD, 1'b1, 3, IO_WAIT + 5, 1'b0,
			"I/O write with wait");
	endtask

	task automatic test_unmapped();
		check_transfer(REG_NONE, 11'h0aa, 11'h008, SZ_WORD, 1'b0, 0, 1, 1'b1,
			"unmapped read");
	endtask

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
		$display("Watchdog expired after %0d cycles before the tests finished",
			WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		psize = SZ_BYTE;
		wait_l = 1'b1;
		pin_errors = 0;
		latency_errors = 0;
		flag_errors = 0;
		timeouts = 0;
		rng = 32'h0b52cd1a;
		row_open = 1'b0;
		open_row_model = '0;
		wait (resetl === 1'b1);
		@(negedge sys_clk);
		test_reset_and_page_open();
		test_page_miss();
		test_dram_random();
		test_rom();
		test_io_wait();
		test_unmapped();
		$display("Errors: %0d pins, %0d latency, %0d flag, %0d timeout", pin_errors,
			latency_errors, flag_errors, timeouts);
		if (pin_errors + latency_errors + flag_errors + timeouts == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
hdl/memctl_pkg.sv
hdl/wait_counter.sv
hdl/lane_decoder.sv
hdl/strobe_gen.sv
hdl/mem_sequencer.sv
hdl/memctl_top.sv
bench/clk_gen.sv
bench/memctl_properties.sv
bench/memctl_tb.sv

// File: Makefile
# Verilator build and run of the memory controller testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build folder and $(LOG)"

obj_dir/Vmemctl_tb: sources.f $(wildcard hdl/*.sv bench/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module memctl_tb -f sources.f

test: obj_dir/Vmemctl_tb
	-./obj_dir/Vmemctl_tb > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG) || ! grep -q "Simulation passed" $(LOG); then \
		echo "test: FAIL"; exit 1; \
	else \
		echo "test: PASS"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
